// File: Bender.yml
package:
  name: run_merger

sources:
  - verilog/merge_pkg.sv
  - verilog/run_buffer.sv
  - verilog/batch_cursor.sv
  - verilog/merge_control.sv
  - verilog/bitonic_merge_16.sv
  - verilog/run_merger.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/run_merger_tb.sv

// File: sim/run_merger_tb.sv
module run_merger_tb
   import merge_pkg::*;
();

   logic             clk;
   logic             reset;
   logic             load;
   run_sel_t         load_run;
   logic [PTR_W-1:0] load_idx;
   batch_t           load_batch;
   logic             start;
   logic             busy;
   logic             out_valid;
   batch_t           out_batch;
   logic             done;

   logic [31:0] lfsr;
   key_t        keys_a [$];
   key_t        keys_b [$];
   key_t        expected [$];
   key_t        got [$];
   int          out_count = 0;
   key_t        prev_key = '0;
   int          errors;
   int          tests;
   logic        idle_phase;
   logic        hung;

   tb_clock tb_clock_inst (
      .o_clk (clk)
   );

   run_merger run_merger_inst (
      .i_clk        (clk),
      .i_reset      (reset),
      .i_load       (load),
      .i_load_run   (load_run),
      .i_load_idx   (load_idx),
      .i_load_batch (load_batch),
      .i_start      (start),
      .o_busy       (busy),
      .o_out_valid  (out_valid),
      .o_out_batch  (out_batch),
      .o_done       (done)
   );

   // Galois LFSR stepped once per bit
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
         lfsr = lfsr ^ 32'h80200003;
      end
      return b;
   endfunction

   function automatic key_t random_key();
      key_t k;
      k = '0;
      for (int i = 0; i < KEY_W; i++) begin
         k = {k[KEY_W-2:0], lfsr_bit()};
      end
      return k;
   endfunction

   // Index of the first key below its predecessor or -1 if none
   function automatic int first_unsorted(batch_t b, key_t prev);
      key_t last;
      last = prev;
      for (int i = 0; i < BATCH_KEYS; i++) begin
         if (b[i] < last) begin
            return i;
         end
         last = b[i];
      end
      return -1;
   endfunction

   task automatic report_order(batch_t b, key_t prev);
      int   idx;
      key_t lower;
      idx = first_unsorted(b, prev);
      if (idx < 0) begin
         idx = 0;
      end
      lower = (idx == 0) ? prev : b[idx-1];
      errors++;
      $display("FAILED %0t o_out_batch[%0d] expected >= %h, got %h",
               $time, idx, lower, b[idx]);
   endtask

   // Output collector restarted by an accepted start
   always @(posedge clk) begin
      if (start && !busy) begin
         got.delete();
         out_count <= 0;
         prev_key <= '0;
      end else if (out_valid) begin
         for (int k = 0; k < BATCH_KEYS; k++) begin
            got.push_back(out_batch[k]);
         end
         out_count <= out_count + 1;
         prev_key <= out_batch[BATCH_KEYS-1];
      end
   end

   a_idle_outputs: assert property (
      @(posedge clk) disable iff (reset)
      idle_phase |-> {busy, out_valid, done} == 3'b000
   ) else begin
      errors++;
      $display("FAILED %0t {o_busy,o_out_valid,o_done} expected 000, got %b",
               $time, $sampled({busy, out_valid, done}));
   end

   a_sorted: assert property (
      @(posedge clk) disable iff (reset)
      out_valid |-> first_unsorted(out_batch, prev_key) < 0
   ) else report_order($sampled(out_batch), $sampled(prev_key));

   a_count_at_done: assert property (
      @(posedge clk) disable iff (reset)
      done |-> out_count == 2 * RUN_BATCHES
   ) else begin
      errors++;
      $display("FAILED %0t o_out_valid count expected %0d, got %0d",
               $time, 2 * RUN_BATCHES, $sampled(out_count));
   end

   a_done_after_last: assert property (
      @(posedge clk) disable iff (reset)
      done |-> $past(out_valid) && $past(busy) && !busy
   ) else begin
      errors++;
      $display("%0t: o_done did not follow the last output with o_busy dropping", $time);
   end

   a_valid_in_busy: assert property (
      @(posedge clk) disable iff (reset)
      out_valid |-> busy
   ) else begin
      errors++;
      $display("%0t: o_out_valid raised while o_busy was low", $time);
   end

   task automatic fill_random();
      keys_a.delete();
      keys_b.delete();
      for (int i = 0; i < RUN_BATCHES * BATCH_KEYS; i++) begin
         keys_a.push_back(random_key());
         keys_b.push_back(random_key());
      end
      keys_a.sort();
      keys_b.sort();
   endtask

   // Run A entirely below run B
   task automatic fill_split();
      key_t all [$];
      int   n;
      n = RUN_BATCHES * BATCH_KEYS;
      for (int i = 0; i < 2 * n; i++) begin
         all.push_back(random_key());
      end
      all.sort();
      keys_a = all[0:n-1];
      keys_b = all[n:2*n-1];
   endtask

   task automatic fill_same();
      keys_a.delete();
      for (int i = 0; i < RUN_BATCHES * BATCH_KEYS; i++) begin
         keys_a.push_back(random_key());
      end
      keys_a.sort();
      keys_b = keys_a;
   endtask

   task automatic load_runs();
      for (int r = 0; r < 2; r++) begin
         for (int b = 0; b < RUN_BATCHES; b++) begin
            @(negedge clk);
            load = 1'b1;
            load_run = (r == 0) ? RUN_A : RUN_B;
            load_idx = PTR_W'(b);
            for (int k = 0; k < BATCH_KEYS; k++) begin
               if (r == 0) begin
                  load_batch[k] = keys_a[b * BATCH_KEYS + k];
               end else begin
                  load_batch[k] = keys_b[b * BATCH_KEYS + k];
               end
            end
         end
      end
      @(negedge clk);
      load = 1'b0;
      expected = {keys_a, keys_b};
      expected.sort();
   endtask

   task automatic pulse_start();
      @(negedge clk);
      start = 1'b1;
      idle_phase = 1'b0;
      @(negedge clk);
      start = 1'b0;
   endtask

   // Start and an all-ones batch while the merge runs
   task automatic poke_while_busy();
      int cycles;
      cycles = 0;
      while (!busy && cycles < 20) begin
         @(negedge clk);
         cycles++;
      end
      if (!busy) begin
         hung = 1'b1;
         $display("timeout: o_busy never rose after start");
      end else begin
         start = 1'b1;
         load = 1'b1;
         load_run = RUN_A;
         load_idx = '0;
         load_batch = '1;
         @(negedge clk);
         start = 1'b0;
         load = 1'b0;
      end
   endtask

   task automatic wait_done(string name);
      int cycles;
      cycles = 0;
      while (!done && cycles < 200) begin
         @(negedge clk);
         cycles++;
      end
      if (!done) begin
         hung = 1'b1;
         $display("timeout: no o_done within 200 cycles in test %s", name);
      end
   endtask

   // Sorted output against the sorted loaded keys
   task automatic check_keys();
      key_t sorted_got [$];
      logic bad;
      sorted_got = got;
      sorted_got.sort();
      bad = 1'b0;
      for (int i = 0; i < expected.size() && !bad; i++) begin
         assert (i < sorted_got.size() && sorted_got[i] == expected[i]) else begin
            bad = 1'b1;
            errors++;
            $display("FAILED %0t sorted o_out_batch key %0d expected %h, got %h",
                     $time, i, expected[i], sorted_got[i]);
         end
      end
   endtask

   task automatic run_test(string name, logic reload, logic poke);
      int errors_at_start;
      errors_at_start = errors;
      if (reload) begin
         load_runs();
      end
      pulse_start();
      if (poke) begin
         poke_while_busy();
      end
      if (!hung) begin
         wait_done(name);
      end
      if (!hung) begin
         check_keys();
      end
      tests++;
      $display("test %s finished, %0d outputs, %0d errors", name, out_count,
               errors - errors_at_start);
   endtask

   initial begin
      lfsr = 32'haf49ad35;
      errors = 0;
      tests = 0;
      hung = 1'b0;
      idle_phase = 1'b1;
      reset = 1'b1;
      load = 1'b0;
      load_run = RUN_A;
      load_idx = '0;
      load_batch = '0;
      start = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      // A few quiet cycles before the first load
      repeat (4) @(negedge clk);
      fill_random();
      run_test("random", 1'b1, 1'b0);
      if (!hung) begin
         fill_split();
         run_test("a below b", 1'b1, 1'b0);
      end
      if (!hung) begin
         fill_same();
         run_test("equal runs", 1'b1, 1'b0);
      end
      if (!hung) begin
         fill_random();
         run_test("busy inputs", 1'b1, 1'b1);
      end
      // Same buffer again so the ignored load must not show
      if (!hung) begin
         run_test("busy rerun", 1'b0, 1'b0);
      end
      $display("tests %0d, errors %0d", tests, errors);
      if (errors == 0 && !hung) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: sim/tb_clock.sv
module tb_clock (
   output logic o_clk
);

   // 40 time units per cycle
   initial begin
      o_clk = 1'b0;
      forever #20 o_clk = ~o_clk;
   end

endmodule

// File: verilog.f
verilog/merge_pkg.sv
verilog/run_buffer.sv
verilog/batch_cursor.sv
verilog/merge_control.sv
verilog/bitonic_merge_16.sv
verilog/run_merger.sv
sim/tb_clock.sv
sim/run_merger_tb.sv

// File: verilog/batch_cursor.sv
module batch_cursor
   import merge_pkg::*;
(
   input  logic             i_clk,
   input  logic             i_reset,

   input  logic             i_clear,
   input  logic             i_take,
   input  run_sel_t         i_take_run,

   output logic [PTR_W-1:0] o_ptr_a,
   output logic [PTR_W-1:0] o_ptr_b,
   output logic             o_empty_a,
   output logic             o_empty_b
);

   // One spare bit so a full count means the run is used up
   logic [PTR_W:0] count_a;
   logic [PTR_W:0] count_b;

   always_ff @(posedge i_clk) begin
      if (i_reset || i_clear) begin
         count_a <= '0;
         count_b <= '0;
      end else if (i_take) begin
         if (i_take_run == RUN_A) begin
            count_a <= count_a + 1'b1;
         end else begin
            count_b <= count_b + 1'b1;
         end
      end
   end

   assign o_ptr_a = count_a[PTR_W-1:0];
   assign o_ptr_b = count_b[PTR_W-1:0];

   assign o_empty_a = (count_a == (PTR_W+1)'(RUN_BATCHES));
   assign o_empty_b = (count_b == (PTR_W+1)'(RUN_BATCHES));

   a_take_not_empty: assert property (
      @(posedge i_clk) disable iff (i_reset)
      i_take && !i_clear |-> ((i_take_run == RUN_A) ? !o_empty_a : !o_empty_b)
   ) else $error("batch_cursor: take from exhausted run");

endmodule

// File: verilog/bitonic_merge_16.sv
module bitonic_merge_16
   import merge_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_reset,

   input  logic     i_stall,
   input  net_tag_t i_tag,
   input  batch_t   i_lo,
   input  batch_t   i_hi,

   output logic     o_stall,
   output net_tag_t o_tag,
   output batch_t   o_lo,
   output batch_t   o_hi
);

   // Stage registers with index 0 as the first stage
   logic     stall_q [NET_STAGES];
   net_tag_t tag_q   [NET_STAGES];
   batch_t   lo_q    [NET_STAGES];
   batch_t   hi_q    [NET_STAGES];

   batch_t cross_lo;
   batch_t cross_hi;

   // Compare-exchange at a fixed distance inside one half
   function automatic batch_t half_clean(batch_t b, int distance);
      batch_t r;
      r = b;
      for (int i = 0; i < BATCH_KEYS; i++) begin
         if ((i & distance) == 0) begin
            if (b[i] > b[i + distance]) begin
               r[i] = b[i + distance];
               r[i + distance] = b[i];
            end
         end
      end
      return r;
   endfunction

   // Key i of the low batch against key 7-i of the high batch
   always_comb begin
      cross_lo = i_lo;
      cross_hi = i_hi;
      for (int i = 0; i < BATCH_KEYS; i++) begin
         if (i_lo[i] > i_hi[BATCH_KEYS-1-i]) begin
            cross_lo[i] = i_hi[BATCH_KEYS-1-i];
            cross_hi[BATCH_KEYS-1-i] = i_lo[i];
         end
      end
   end

   // Stage 1
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         stall_q[0] <= 1'b1;
      end else begin
         stall_q[0] <= i_stall;
      end
      if (!i_stall) begin
         tag_q[0] <= i_tag;
         lo_q[0] <= cross_lo;
         hi_q[0] <= cross_hi;
      end
   end

   // Stages 2 to 4 clean at distances 4, 2 and 1
   for (genvar s = 1; s < NET_STAGES; s++) begin : g_clean
      always_ff @(posedge i_clk) begin
         if (i_reset) begin
            stall_q[s] <= 1'b1;
         end else begin
            stall_q[s] <= stall_q[s-1];
         end
         if (!stall_q[s-1]) begin
            tag_q[s] <= tag_q[s-1];
            lo_q[s] <= half_clean(lo_q[s-1], BATCH_KEYS >> s);
            hi_q[s] <= half_clean(hi_q[s-1], BATCH_KEYS >> s);
         end
      end
   end

   assign o_stall = stall_q[NET_STAGES-1];
   assign o_tag = tag_q[NET_STAGES-1];
   assign o_lo = lo_q[NET_STAGES-1];
   assign o_hi = hi_q[NET_STAGES-1];

   // A bubble at the output never disturbs the last result
   a_hold_on_stall: assert property (
      @(posedge i_clk) disable iff (i_reset)
      o_stall ##1 o_stall |-> $stable(o_lo) && $stable(o_hi)
   ) else $error("bitonic_merge_16: output changed under stall");

endmodule

// File: verilog/merge_control.sv
module merge_control
   import merge_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_reset,
   input  logic     i_start,

   input  batch_t   i_head_a,
   input  batch_t   i_head_b,
   input  logic     i_empty_a,
   input  logic     i_empty_b,

   input  logic     i_net_stall,
   input  batch_t   i_net_lo,
   input  batch_t   i_net_hi,
   input  net_tag_t i_net_tag,

   output logic     o_clear,
   output logic     o_take,
   output run_sel_t o_take_run,

   output logic     o_net_stall,
   output batch_t   o_net_lo,
   output batch_t   o_net_hi,
   output net_tag_t o_net_tag,

   output logic     o_busy,
   output logic     o_out_valid,
   output batch_t   o_out_batch,
   output logic     o_done
);

   merge_state_t      state;
   batch_t            held;
   logic [PTR_W:0]    rounds_left;
   logic [WAIT_W-1:0] wait_cnt;
   logic              pick_b;
   logic              result;

   // Smaller head key wins, a tie goes to run A
   assign pick_b = i_empty_a || (!i_empty_b && (i_head_b[0] < i_head_a[0]));
   assign result = !i_net_stall;

   assign o_clear = (state == ST_IDLE) && i_start;
   assign o_take = (state == ST_PRIME) || (state == ST_ISSUE);
   assign o_take_run = pick_b ? RUN_B : RUN_A;

   // Network sees one bubble-free cycle per round
   assign o_net_stall = (state != ST_ISSUE);
   assign o_net_lo = held;
   assign o_net_hi = pick_b ? i_head_b : i_head_a;

   always_comb begin
      o_net_tag.last = (rounds_left == (PTR_W+1)'(1));
      o_net_tag.first = (rounds_left == (PTR_W+1)'(MERGE_ROUNDS));
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state <= ST_IDLE;
         rounds_left <= '0;
         wait_cnt <= '0;
         o_busy <= 1'b0;
         o_out_valid <= 1'b0;
         o_done <= 1'b0;
      end else begin
         o_out_valid <= 1'b0;
         o_done <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (i_start) begin
                  o_busy <= 1'b1;
                  state <= ST_PRIME;
               end
            end
            ST_PRIME: begin
               rounds_left <= (PTR_W+1)'(MERGE_ROUNDS);
               state <= ST_ISSUE;
            end
            ST_ISSUE: begin
               rounds_left <= rounds_left - 1'b1;
               wait_cnt <= '0;
               state <= ST_WAIT;
            end
            ST_WAIT: begin
               wait_cnt <= wait_cnt + 1'b1;
               if (result) begin
                  o_out_valid <= 1'b1;
                  state <= i_net_tag.last ? ST_FLUSH : ST_ISSUE;
               end
            end
            ST_FLUSH: begin
               o_out_valid <= 1'b1;
               state <= ST_DONE;
            end
            ST_DONE: begin
               o_done <= 1'b1;
               o_busy <= 1'b0;
               state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Held batch keeps the upper half between rounds
   always_ff @(posedge i_clk) begin
      if (state == ST_PRIME) begin
         held <= pick_b ? i_head_b : i_head_a;
      end else if (result) begin
         held <= i_net_hi;
      end
      if (result) begin
         o_out_batch <= i_net_lo;
      end else if (state == ST_FLUSH) begin
         o_out_batch <= held;
      end
   end

   a_result_in_wait: assert property (
      @(posedge i_clk) disable iff (i_reset)
      result |-> (state == ST_WAIT) && (wait_cnt == WAIT_W'(NET_STAGES - 1))
   ) else $error("merge_control: network result outside its wait slot");

   a_first_round: assert property (
      @(posedge i_clk) disable iff (i_reset)
      result && i_net_tag.first |-> rounds_left == (PTR_W+1)'(MERGE_ROUNDS - 1)
   ) else $error("merge_control: first tag on a later round");

endmodule

// File: verilog/merge_pkg.sv
package merge_pkg;

   // Key and batch geometry
   localparam int KEY_W = 32;
   localparam int BATCH_KEYS = 8;
   localparam int RUN_BATCHES = 4;
   localparam int PTR_W = 2;

   // Pipeline depth of the bitonic network
   localparam int NET_STAGES = 4;
   localparam int WAIT_W = $clog2(NET_STAGES);

   // One batch is primed, every other batch costs one network round
   localparam int MERGE_ROUNDS = 2 * RUN_BATCHES - 1;

   typedef logic [KEY_W-1:0] key_t;

   // Key 0 sits in the low word, sorted batches ascend from key 0
   typedef key_t [BATCH_KEYS-1:0] batch_t;

   // Rides beside the data through the network
   typedef struct packed {
      logic last;
      logic first;
   } net_tag_t;

   typedef enum logic {
      RUN_A,
      RUN_B
   } run_sel_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_PRIME,
      ST_ISSUE,
      ST_WAIT,
      ST_FLUSH,
      ST_DONE
   } merge_state_t;

endpackage

// File: verilog/run_buffer.sv
module run_buffer
   import merge_pkg::*;
(
   input  logic             i_clk,
   input  logic             i_reset,

   input  logic             i_load,
   input  run_sel_t         i_load_run,
   input  logic [PTR_W-1:0] i_load_idx,
   input  batch_t           i_load_batch,

   input  logic             i_busy,

   input  logic [PTR_W-1:0] i_ptr_a,
   input  logic [PTR_W-1:0] i_ptr_b,
   output batch_t           o_head_a,
   output batch_t           o_head_b
);

   batch_t run_a [RUN_BATCHES];
   batch_t run_b [RUN_BATCHES];

   logic write_en;

   // Contents are frozen while a merge reads them
   assign write_en = i_load && !i_busy;

   always_ff @(posedge i_clk) begin
      if (write_en) begin
         if (i_load_run == RUN_A) begin
            run_a[i_load_idx] <= i_load_batch;
         end else begin
            run_b[i_load_idx] <= i_load_batch;
         end
      end
   end

   // Head batches for the control compare
   assign o_head_a = run_a[i_ptr_a];
   assign o_head_b = run_b[i_ptr_b];

   a_load_idx_range: assert property (
      @(posedge i_clk) disable iff (i_reset)
      write_en |-> int'(i_load_idx) < RUN_BATCHES
   ) else $error("run_buffer: load index %0d beyond run length", i_load_idx);

endmodule

// File: verilog/run_merger.sv
module run_merger
   import merge_pkg::*;
(
   input  logic             i_clk,
   input  logic             i_reset,

   input  logic             i_load,
   input  run_sel_t         i_load_run,
   input  logic [PTR_W-1:0] i_load_idx,
   input  batch_t           i_load_batch,

   input  logic             i_start,
   output logic             o_busy,

   output logic             o_out_valid,
   output batch_t           o_out_batch,
   output logic             o_done
);

   logic [PTR_W-1:0] ptr_a;
   logic [PTR_W-1:0] ptr_b;
   logic             empty_a;
   logic             empty_b;
   batch_t           head_a;
   batch_t           head_b;

   logic             clear;
   logic             take;
   run_sel_t         take_run;

   // Control to network and back
   logic             to_net_stall;
   batch_t           to_net_lo;
   batch_t           to_net_hi;
   net_tag_t         to_net_tag;
   logic             from_net_stall;
   batch_t           from_net_lo;
   batch_t           from_net_hi;
   net_tag_t         from_net_tag;

   run_buffer run_buffer_inst (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_load       (i_load),
      .i_load_run   (i_load_run),
      .i_load_idx   (i_load_idx),
      .i_load_batch (i_load_batch),
      .i_busy       (o_busy),
      .i_ptr_a      (ptr_a),
      .i_ptr_b      (ptr_b),
      .o_head_a     (head_a),
      .o_head_b     (head_b)
   );

   batch_cursor batch_cursor_inst (
      .i_clk      (i_clk),
      .i_reset    (i_reset),
      .i_clear    (clear),
      .i_take     (take),
      .i_take_run (take_run),
      .o_ptr_a    (ptr_a),
      .o_ptr_b    (ptr_b),
      .o_empty_a  (empty_a),
      .o_empty_b  (empty_b)
   );

   merge_control merge_control_inst (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_start     (i_start),
      .i_head_a    (head_a),
      .i_head_b    (head_b),
      .i_empty_a   (empty_a),
      .i_empty_b   (empty_b),
      .i_net_stall (from_net_stall),
      .i_net_lo    (from_net_lo),
      .i_net_hi    (from_net_hi),
      .i_net_tag   (from_net_tag),
      .o_clear     (clear),
      .o_take      (take),
      .o_take_run  (take_run),
      .o_net_stall (to_net_stall),
      .o_net_lo    (to_net_lo),
      .o_net_hi    (to_net_hi),
      .o_net_tag   (to_net_tag),
      .o_busy      (o_busy),
      .o_out_valid (o_out_valid),
      .o_out_batch (o_out_batch),
      .o_done      (o_done)
   );

   bitonic_merge_16 bitonic_merge_16_inst (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_stall (to_net_stall),
      .i_tag   (to_net_tag),
      .i_lo    (to_net_lo),
      .i_hi    (to_net_hi),
      .o_stall (from_net_stall),
      .o_tag   (from_net_tag),
      .o_lo    (from_net_lo),
      .o_hi    (from_net_hi)
   );

endmodule
